// File: Makefile
# Verilator lint, simulation and clean for the RV32 core
VERILATOR ?= verilator
TOP ?= core_tb
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | awk '{ print } index($$0, "$(PASS_TEXT)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/core_tb.sv
// core testbench checking random programs against an in-order reference model
`timescale 1ns/100ps
`include "core_params.svh"

module core_tb;
	import core_pkg::*;

	localparam int TIMEOUT = 400;
	localparam logic [31:0] EBREAK = 32'h0010_0073;

	logic clk;
	logic rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic dmem_wen;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic halt;
	logic illegal;
	logic commit_valid;
	logic [31:0] commit_pc;
	inst_kind_e commit_kind;
	logic [4:0] commit_rd;
	logic [31:0] commit_wdata;

	// program image and expected trace
	logic [31:0] imem [256];
	logic [7:0] prog_len;
	logic [31:0] exp_pc [128];
	inst_kind_e exp_kind [128];
	logic [4:0] exp_rd [128];
	logic [31:0] exp_wd [128];
	logic [31:0] exp_st_addr [128];
	logic [31:0] exp_st_data [128];
	logic [6:0] exp_n;
	logic [6:0] st_n;
	logic exp_illegal;
	logic [6:0] cidx;
	logic [6:0] sidx;
	logic [31:0] lfsr;
	int errors;
	int err_mark;
	int tests;
	int fails;

	core_top UUT (.*);

	always #4 clk = ~clk;

	assign imem_data = imem[imem_addr[9:2]];

	// next commit and store the trace must show
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cidx <= '0;
			sidx <= '0;
		end else begin
			if (commit_valid) cidx <= cidx + 7'd1;
			if (dmem_wen) sidx <= sidx + 7'd1;
		end
	end

	task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic unexpected(string what);
		$display("ERROR at %0t: %s", $time, what);
		errors++;
	endtask

	assert property (@(posedge clk) disable iff (!rst_n) commit_valid |-> cidx < exp_n)
		else unexpected("an instruction committed after the last expected one");
	assert property (@(posedge clk) disable iff (!rst_n) commit_valid |-> commit_pc == exp_pc[cidx])
		else mismatch("commit_pc", $sampled(commit_pc), $sampled(exp_pc[cidx]));
	assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid |-> commit_kind == exp_kind[cidx])
		else mismatch("commit_kind", 32'($sampled(commit_kind)), 32'($sampled(exp_kind[cidx])));
	assert property (@(posedge clk) disable iff (!rst_n) commit_valid |-> commit_rd == exp_rd[cidx])
		else mismatch("commit_rd", 32'($sampled(commit_rd)), 32'($sampled(exp_rd[cidx])));
	assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid |-> commit_wdata == exp_wd[cidx])
		else mismatch("commit_wdata", $sampled(commit_wdata), $sampled(exp_wd[cidx]));
	assert property (@(posedge clk) disable iff (!rst_n) dmem_wen |-> sidx < st_n)
		else unexpected("a store happened with no matching sw");
	assert property (@(posedge clk) disable iff (!rst_n) dmem_wen |-> dmem_addr == exp_st_addr[sidx])
		else mismatch("dmem_addr", $sampled(dmem_addr), $sampled(exp_st_addr[sidx]));
	assert property (@(posedge clk) disable iff (!rst_n)
		dmem_wen |-> dmem_wdata == exp_st_data[sidx])
		else mismatch("dmem_wdata", $sampled(dmem_wdata), $sampled(exp_st_data[sidx]));

	// galois lfsr on x^32 + x^22 + x^2 + x + 1 with one step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// instruction encoders
	function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b001_0011};
	endfunction
	function automatic logic [31:0] lui(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'b011_0111};
	endfunction
	function automatic logic [31:0] auipc(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'b001_0111};
	endfunction
	function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
	endfunction
	function automatic logic [31:0] jalr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b110_0111};
	endfunction
	function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
	endfunction

	task automatic emit(logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// unused words decode as illegal with opcode 0
	task automatic clear_program();
		for (int i = 0; i < 256; i++) begin
			imem[8'(i)] = {8'(i), 8'(~i), 9'(i), 7'h00};
		end
		prog_len = '0;
	endtask

	// random addi, lui and auipc on x0..x7 so registers are reused often
	task automatic arith_program(int n);
		logic [4:0] rd;
		logic [4:0] rs;
		for (int i = 0; i < n; i++) begin
			rd = 5'(rand_bits(3));
			rs = 5'(rand_bits(3));
			case (2'(rand_bits(2)))
				2'd2: emit(lui(rd, 20'(rand_bits(20))));
				2'd3: emit(auipc(rd, 20'(rand_bits(20))));
				default: emit(addi(rd, rs, 12'(rand_bits(12))));
			endcase
		end
	endtask

	// in-order model of the subset that builds expected commits and stores
	task automatic run_model();
		logic [31:0] r [32];
		logic [31:0] pc;
		logic [31:0] next;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] imm_i;
		logic [31:0] val;
		inst_kind_e k;
		logic wr;
		for (int i = 0; i < 32; i++) begin
			r[5'(i)] = '0;
		end
		pc = `CORE_RESET_PC;
		exp_n = '0;
		st_n = '0;
		exp_illegal = 1'b0;
		while (exp_n != 7'd127) begin
			w = imem[pc[9:2]];
			a = r[w[19:15]];
			imm_i = {{20{w[31]}}, w[31:20]};
			k = kind_illegal;
			if (w[6:0] == 7'h13 && w[14:12] == 3'd0) k = kind_addi;
			if (w[6:0] == 7'h37) k = kind_lui;
			if (w[6:0] == 7'h17) k = kind_auipc;
			if (w[6:0] == 7'h6f) k = kind_jal;
			if (w[6:0] == 7'h67 && w[14:12] == 3'd0) k = kind_jalr;
			if (w[6:0] == 7'h23 && w[14:12] == 3'd2) k = kind_sw;
			if (w == EBREAK) k = kind_ebreak;
			next = pc + 32'd4;
			case (k)
				kind_addi: val = a + imm_i;
				kind_lui: val = {w[31:12], 12'd0};
				kind_auipc: val = pc + {w[31:12], 12'd0};
				default: val = pc + 32'd4;
			endcase
			if (k == kind_jal) next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			if (k == kind_jalr) next = (a + imm_i) & ~32'h1;
			if (k == kind_sw) begin
				exp_st_addr[st_n] = a + {{20{w[31]}}, w[31:25], w[11:7]};
				exp_st_data[st_n] = r[w[24:20]];
				st_n++;
			end
			wr = k inside {kind_addi, kind_lui, kind_auipc, kind_jal, kind_jalr};
			exp_pc[exp_n] = pc;
			exp_kind[exp_n] = k;
			exp_rd[exp_n] = wr ? w[11:7] : 5'd0;
			exp_wd[exp_n] = (wr && w[11:7] != 5'd0) ? val : 32'd0;
			exp_n++;
			if (wr && w[11:7] != 5'd0) r[w[11:7]] = val;
			if (k == kind_ebreak || k == kind_illegal) begin
				exp_illegal = (k == kind_illegal);
				break;
			end
			pc = next;
		end
	endtask

	task automatic begin_test();
		@(negedge clk);
		rst_n = 1'b0;
		err_mark = errors;
		clear_program();
	endtask

	// reset stays low for 16 cycles in all
	task automatic start_core();
		run_model();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic finish_test(string name);
		int cyc;
		cyc = 0;
		while (!halt && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (!halt) unexpected($sformatf("%s did not halt within %0d cycles", name, TIMEOUT));
		// a few idle cycles so late commits would show
		repeat (4) @(negedge clk);
		assert (illegal == exp_illegal) else mismatch("illegal", 32'(illegal), 32'(exp_illegal));
		assert (cidx == exp_n) else mismatch("commit count", 32'(cidx), 32'(exp_n));
		assert (sidx == st_n) else mismatch("store count", 32'(sidx), 32'(st_n));
		tests++;
		if (errors != err_mark) fails++;
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "pass" : "fail");
	endtask

	initial begin
		int cyc;
		clk = 1'b0;
		rst_n = 1'b0;
		lfsr = 32'd64;
		errors = 0;
		tests = 0;
		fails = 0;
		clear_program();

		// chains with back-to-back reuse then a write to x0 and a read of it
		begin_test();
		arith_program(24);
		emit(addi(5'd0, 5'd1, 12'h7ff));
		emit(addi(5'd2, 5'd0, 12'(rand_bits(12))));
		emit(addi(5'd2, 5'd2, 12'd1));
		emit(EBREAK);
		start_core();
		finish_test("arithmetic");

		// jal over two words and jalr with an odd offset before both links are read
		begin_test();
		emit(addi(5'd4, 5'd0, 12'(rand_bits(12))));
		emit(jal(5'd1, 21'd12));
		emit(addi(5'd4, 5'd4, 12'd1));
		emit(addi(5'd4, 5'd4, 12'd2));
		emit(auipc(5'd3, 20'd0));
		emit(jalr(5'd2, 5'd3, 12'd17));
		emit(addi(5'd4, 5'd4, 12'd3));
		emit(addi(5'd4, 5'd4, 12'd4));
		emit(addi(5'd5, 5'd1, 12'd0));
		emit(addi(5'd6, 5'd2, 12'd0));
		emit(EBREAK);
		start_core();
		finish_test("jumps");

		// store data produced by the instruction just before
		begin_test();
		emit(lui(5'd1, 20'(rand_bits(20))));
		emit(addi(5'd2, 5'd0, 12'(rand_bits(12))));
		for (int i = 0; i < 6; i++) begin
			emit(addi(5'd2, 5'd2, 12'(rand_bits(12))));
			emit(sw(5'd2, 5'd1, 12'(rand_bits(12))));
		end
		emit(sw(5'd0, 5'd1, 12'hffc));
		emit(EBREAK);
		start_core();
		finish_test("stores");

		begin_test();
		arith_program(6);
		emit(EBREAK);
		emit(addi(5'd1, 5'd1, 12'd1));
		emit(sw(5'd1, 5'd0, 12'd0));
		emit(addi(5'd2, 5'd2, 12'd2));
		start_core();
		finish_test("ebreak");

		// a load word outside the subset
		begin_test();
		arith_program(4);
		emit(32'h0000_2083);
		emit(addi(5'd1, 5'd1, 12'd1));
		emit(EBREAK);
		start_core();
		finish_test("illegal opcode");

		// halt from the last test must clear and the core restarts mid-program
		begin_test();
		arith_program(30);
		emit(EBREAK);
		start_core();
		assert (!halt) else mismatch("halt", 32'(halt), 32'd0);
		cyc = 0;
		while (cidx < 7'd5 && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (cidx < 7'd5) unexpected("no commits before the mid-program reset");
		@(negedge clk);
		rst_n = 1'b0;
		start_core();
		finish_test("reset restart");

		$display("tests %0d, failed %0d, check errors %0d", tests, fails, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: source/core_params.svh
// reset pc, data width and register address width of the core
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h8000_0000

// data and address width
`define CORE_XLEN 32

// register file address width for 32 registers
`define CORE_REG_AW 5

`endif

// File: source/core_pkg.sv
// shared enum types for the fetch, decode and execute stages
package core_pkg;

	// decoded instruction class that the commit port also reports
	typedef enum logic [2:0] {
		kind_addi    = 3'd0,
		kind_lui     = 3'd1,
		kind_auipc   = 3'd2,
		kind_jal     = 3'd3,
		kind_jalr    = 3'd4,
		kind_sw      = 3'd5,
		kind_ebreak  = 3'd6,
		kind_illegal = 3'd7
	} inst_kind_e;

	// fetch unit state where halt is left only through reset
	typedef enum logic {
		fetch_run  = 1'b0,
		fetch_halt = 1'b1
	} fetch_state_e;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_op_imm = 7'b001_0011,
		opc_lui    = 7'b011_0111,
		opc_auipc  = 7'b001_0111,
		opc_jal    = 7'b110_1111,
		opc_jalr   = 7'b110_0111,
		opc_store  = 7'b010_0011,
		opc_system = 7'b111_0011
	} rv_opcode_e;

endpackage

// File: source/core_top.sv
// core top level joining fetch, decode and execute stages with plain memory and trace ports
`timescale 1ns/100ps
`include "core_params.svh"

module core_top (
	input logic clk,
	input logic rst_n,
	// instruction memory
	output logic [`CORE_XLEN-1:0] imem_addr,
	input logic [`CORE_XLEN-1:0] imem_data,
	// data memory
	output logic dmem_wen,
	output logic [`CORE_XLEN-1:0] dmem_addr,
	output logic [`CORE_XLEN-1:0] dmem_wdata,
	// status
	output logic halt,
	output logic illegal,
	// commit trace
	output logic commit_valid,
	output logic [`CORE_XLEN-1:0] commit_pc,
	output core_pkg::inst_kind_e commit_kind,
	output logic [`CORE_REG_AW-1:0] commit_rd,
	output logic [`CORE_XLEN-1:0] commit_wdata
);

	logic kill;
	logic halt_req;
	logic [`CORE_XLEN-1:0] redirect_pc;
	logic fetch_valid;
	logic [`CORE_XLEN-1:0] fetch_pc;
	logic [`CORE_XLEN-1:0] fetch_inst;
	logic wb_en;
	logic [`CORE_REG_AW-1:0] wb_addr;
	logic [`CORE_XLEN-1:0] wb_data;

	dec_exe_if u_dx ();

	ifu u_ifu (
		.clk(clk),
		.rst_n(rst_n),
		.kill(kill),
		.halt_req(halt_req),
		.redirect_pc(redirect_pc),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst)
	);

	idu u_idu (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst),
		.kill(kill),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.dx(u_dx.producer)
	);

	exu u_exu (
		.clk(clk),
		.rst_n(rst_n),
		.dx(u_dx.consumer),
		.kill(kill),
		.halt_req(halt_req),
		.redirect_pc(redirect_pc),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.dmem_wen(dmem_wen),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.halt(halt),
		.illegal(illegal),
		.commit_valid(commit_valid),
		.commit_pc(commit_pc),
		.commit_kind(commit_kind),
		.commit_rd(commit_rd),
		.commit_wdata(commit_wdata)
	);

endmodule

// File: source/dec_exe_if.sv
// decode to execute link carrying one decoded instruction per cycle
`timescale 1ns/100ps
`include "core_params.svh"

interface dec_exe_if;
	import core_pkg::*;

	logic valid;
	inst_kind_e kind;
	logic [`CORE_XLEN-1:0] pc;
	// operands summed in execute
	logic [`CORE_XLEN-1:0] src1;
	logic [`CORE_XLEN-1:0] src2;
	logic [`CORE_XLEN-1:0] store_data;
	logic [`CORE_REG_AW-1:0] rd;

	modport producer (
		output valid, kind, pc, src1, src2, store_data, rd
	);

	modport consumer (
		input valid, kind, pc, src1, src2, store_data, rd
	);

endinterface

// File: source/exu.sv
// execute stage for results, writeback, stores, jumps, halt and commit trace
`timescale 1ns/100ps
`include "core_params.svh"

module exu (
	input logic clk,
	input logic rst_n,
	dec_exe_if.consumer dx,
	// to fetch and decode
	output logic kill,
	output logic halt_req,
	output logic [`CORE_XLEN-1:0] redirect_pc,
	// writeback to the register file
	output logic wb_en,
	output logic [`CORE_REG_AW-1:0] wb_addr,
	output logic [`CORE_XLEN-1:0] wb_data,
	// data memory stores
	output logic dmem_wen,
	output logic [`CORE_XLEN-1:0] dmem_addr,
	output logic [`CORE_XLEN-1:0] dmem_wdata,
	// status
	output logic halt,
	output logic illegal,
	// commit trace
	output logic commit_valid,
	output logic [`CORE_XLEN-1:0] commit_pc,
	output core_pkg::inst_kind_e commit_kind,
	output logic [`CORE_REG_AW-1:0] commit_rd,
	output logic [`CORE_XLEN-1:0] commit_wdata
);
	import core_pkg::*;

	logic live;
	logic is_jump;
	logic is_stop;
	logic writes_rd;
	logic [`CORE_XLEN-1:0] sum;
	logic [`CORE_XLEN-1:0] target;
	logic [`CORE_XLEN-1:0] result;

	// nothing retires once halted
	assign live = dx.valid && !halt;

	assign is_jump = (dx.kind == kind_jal) || (dx.kind == kind_jalr);
	assign is_stop = (dx.kind == kind_ebreak) || (dx.kind == kind_illegal);
	assign writes_rd = is_jump || (dx.kind == kind_addi) ||
		(dx.kind == kind_lui) || (dx.kind == kind_auipc);

	// single adder serves every kind
	assign sum = dx.src1 + dx.src2;
	assign target = (dx.kind == kind_jalr) ? {sum[`CORE_XLEN-1:1], 1'b0} : sum;
	// jumps link the next pc
	assign result = is_jump ? dx.pc + `CORE_XLEN'(4) : sum;

	assign kill = live && (is_jump || is_stop);
	assign halt_req = live && is_stop;
	assign redirect_pc = is_jump ? target : '0;

	// x0 writes are dropped here
	assign wb_en = live && writes_rd && (dx.rd != '0);
	assign wb_addr = dx.rd;
	assign wb_data = result;

	assign dmem_wen = live && (dx.kind == kind_sw);
	assign dmem_addr = sum;
	assign dmem_wdata = dx.store_data;

	// rd and value read zero when nothing is written
	assign commit_valid = live;
	assign commit_pc = dx.pc;
	assign commit_kind = dx.kind;
	assign commit_rd = writes_rd ? dx.rd : '0;
	assign commit_wdata = wb_en ? result : '0;

	// sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halt <= 1'b0;
			illegal <= 1'b0;
		end else if (halt_req) begin
			halt <= 1'b1;
			if (dx.kind == kind_illegal) begin
				illegal <= 1'b1;
			end
		end
	end

endmodule

// File: source/idu.sv
// decode stage that classifies the instruction and registers its operands for execute
`timescale 1ns/100ps
`include "core_params.svh"

module idu (
	input logic clk,
	input logic rst_n,
	// from fetch
	input logic fetch_valid,
	input logic [`CORE_XLEN-1:0] fetch_pc,
	input logic [`CORE_XLEN-1:0] fetch_inst,
	// from execute
	input logic kill,
	input logic wb_en,
	input logic [`CORE_REG_AW-1:0] wb_addr,
	input logic [`CORE_XLEN-1:0] wb_data,
	// to execute
	dec_exe_if.producer dx
);
	import core_pkg::*;

	// the whole word is compared and not just the opcode
	localparam logic [`CORE_XLEN-1:0] EBREAK_INST = 32'h0010_0073;

	rv_opcode_e opcode;
	logic [2:0] funct3;
	logic [`CORE_REG_AW-1:0] rs1;
	logic [`CORE_REG_AW-1:0] rs2;
	logic [`CORE_XLEN-1:0] imm_i;
	logic [`CORE_XLEN-1:0] imm_u;
	logic [`CORE_XLEN-1:0] imm_j;
	logic [`CORE_XLEN-1:0] imm_s;
	logic [`CORE_XLEN-1:0] imm;
	logic [`CORE_XLEN-1:0] rs1_data;
	logic [`CORE_XLEN-1:0] rs2_data;
	logic [`CORE_XLEN-1:0] src1;
	inst_kind_e kind;

	assign opcode = rv_opcode_e'(fetch_inst[6:0]);
	assign funct3 = fetch_inst[14:12];
	assign rs1 = fetch_inst[19:15];
	assign rs2 = fetch_inst[24:20];

	assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
	assign imm_u = {fetch_inst[31:12], 12'b0};
	assign imm_j = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
		fetch_inst[30:21], 1'b0};
	assign imm_s = {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};

	regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(rs1),
		.raddr2(rs2),
		.rdata1(rs1_data),
		.rdata2(rs2_data),
		.wen(wb_en),
		.waddr(wb_addr),
		.wdata(wb_data)
	);

	// anything outside the subset falls to illegal
	always_comb begin
		kind = kind_illegal;
		case (opcode)
			opc_op_imm: if (funct3 == 3'b000) kind = kind_addi;
			opc_lui:    kind = kind_lui;
			opc_auipc:  kind = kind_auipc;
			opc_jal:    kind = kind_jal;
			opc_jalr:   if (funct3 == 3'b000) kind = kind_jalr;
			opc_store:  if (funct3 == 3'b010) kind = kind_sw;
			opc_system: if (fetch_inst == EBREAK_INST) kind = kind_ebreak;
			default:    kind = kind_illegal;
		endcase
	end

	// immediate is zero for ebreak and illegal
	always_comb begin
		case (kind)
			kind_addi, kind_jalr: imm = imm_i;
			kind_lui, kind_auipc: imm = imm_u;
			kind_jal:             imm = imm_j;
			kind_sw:              imm = imm_s;
			default:              imm = '0;
		endcase
	end

	// first operand where lui adds to zero
	always_comb begin
		case (kind)
			kind_jal, kind_auipc: src1 = fetch_pc;
			kind_lui:             src1 = '0;
			default:              src1 = rs1_data;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx.valid <= 1'b0;
		end else begin
			dx.valid <= fetch_valid && !kill;
		end
	end

	// decode register payload
	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			dx.kind <= kind;
			dx.pc <= fetch_pc;
			dx.src1 <= src1;
			dx.src2 <= imm;
			dx.store_data <= rs2_data;
			dx.rd <= fetch_inst[11:7];
		end
	end

endmodule

// File: source/ifu.sv
// fetch stage that keeps the pc and registers each fetched word with its address
`timescale 1ns/100ps
`include "core_params.svh"

module ifu (
	input logic clk,
	input logic rst_n,
	// redirect from execute
	input logic kill,
	input logic halt_req,
	input logic [`CORE_XLEN-1:0] redirect_pc,
	// instruction memory answering in the same cycle
	output logic [`CORE_XLEN-1:0] imem_addr,
	input logic [`CORE_XLEN-1:0] imem_data,
	// to decode
	output logic fetch_valid,
	output logic [`CORE_XLEN-1:0] fetch_pc,
	output logic [`CORE_XLEN-1:0] fetch_inst
);
	import core_pkg::*;

	fetch_state_e state;
	logic [`CORE_XLEN-1:0] pc;
	logic running;

	assign running = (state == fetch_run);
	assign imem_addr = pc;

	// pc and run state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= fetch_run;
			pc <= `CORE_RESET_PC;
		end else if (kill) begin
			pc <= redirect_pc;
			// ebreak or illegal stops fetch for good
			if (halt_req) begin
				state <= fetch_halt;
			end
		end else if (running) begin
			pc <= pc + `CORE_XLEN'(4);
		end
	end

	// fetched word is dropped on kill since the younger path is wrong
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= running && !kill;
		end
	end

	// fetch register payload
	always_ff @(posedge clk) begin
		if (running) begin
			fetch_pc <= pc;
			fetch_inst <= imem_data;
		end
	end

endmodule

// File: source/regfile.sv
// 32-entry register file with x0 reading zero and same-cycle writes bypassed to reads
`timescale 1ns/100ps
`include "core_params.svh"

module regfile (
	input logic clk,
	input logic rst_n,
	input logic [`CORE_REG_AW-1:0] raddr1,
	input logic [`CORE_REG_AW-1:0] raddr2,
	output logic [`CORE_XLEN-1:0] rdata1,
	output logic [`CORE_XLEN-1:0] rdata2,
	input logic wen,
	input logic [`CORE_REG_AW-1:0] waddr,
	input logic [`CORE_XLEN-1:0] wdata
);

	// storage for x1..x31 only
	logic [`CORE_XLEN-1:0] regs [31:1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// write-through so decode never waits on execute
	assign rdata1 = (raddr1 == '0) ? '0 :
		(wen && (waddr == raddr1)) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(wen && (waddr == raddr2)) ? wdata : regs[raddr2];

endmodule

// File: sources.f
+incdir+source
source/core_pkg.sv
source/dec_exe_if.sv
source/ifu.sv
source/regfile.sv
source/idu.sv
source/exu.sv
source/core_top.sv
sim/core_tb.sv
